// File: logic/backend_pkg.sv
package backend_pkg;

    localparam int NUM_AREG  = 8;
    localparam int NUM_PREG  = 16;
    localparam int ROB_DEPTH = 8;
    localparam int IQ_DEPTH  = 4;

    typedef logic [15:0] data_t;
    typedef logic [2:0]  areg_t;
    typedef logic [3:0]  preg_t;
    typedef logic [2:0]  rob_idx_t;

    // bit 3 set means rs2 slot holds an immediate
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h8,
        OP_ANDI = 4'h9
    } alu_op_t;

    typedef struct packed {
        alu_op_t     opcode;
        areg_t       rd;
        areg_t       rs1;
        areg_t       rs2;
        logic [2:0]  unused;
    } inst_r_t;

    typedef struct packed {
        alu_op_t           opcode;
        areg_t             rd;
        areg_t             rs1;
        logic signed [5:0] imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef struct packed {
        alu_op_t  op;
        preg_t    prd;
        preg_t    prs1;
        preg_t    prs2;
        logic     rs2_imm;
        data_t    imm;      // already sign extended
        rob_idx_t rob_idx;
    } iq_entry_t;

endpackage

// File: logic/backend_if.sv
`timescale 1ns/1ns

interface dispatch_if;
    logic                   valid;
    backend_pkg::iq_entry_t entry;
    backend_pkg::areg_t     areg;
    backend_pkg::preg_t     old_prd;
    logic                   src1_ready;
    logic                   src2_ready;
    backend_pkg::rob_idx_t  rob_idx;    // rob tail

    modport rename_side (
        output valid, entry, areg, old_prd, src1_ready, src2_ready,
        input  rob_idx
    );
    modport rob_side (
        input  valid, areg, old_prd,
        output rob_idx
    );
    modport iq_side (
        input valid, entry, src1_ready, src2_ready, rob_idx
    );
endinterface

interface wb_if;
    logic                  en;
    backend_pkg::preg_t    prd;
    backend_pkg::rob_idx_t rob_idx;
    backend_pkg::data_t    data;

    modport source (output en, prd, rob_idx, data);
    modport sink   (input  en, prd, rob_idx, data);
endinterface

// File: logic/rename.sv
`timescale 1ns/1ns

module rename #(
    parameter int NUM_AREG = backend_pkg::NUM_AREG,
    parameter int NUM_PREG = backend_pkg::NUM_PREG
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  backend_pkg::inst_t  inst,
    output logic                stall,
    dispatch_if.rename_side     dis,
    wb_if.sink                  wb,
    input  logic                free_en,
    input  backend_pkg::preg_t  free_preg,
    input  logic                rob_full,
    input  logic                iq_full
);
    localparam int PW = $clog2(NUM_PREG);

    backend_pkg::preg_t     rat_q  [NUM_AREG];
    backend_pkg::preg_t     fl_mem [NUM_PREG];
    logic [NUM_PREG-1:0]    busy_q;
    logic [PW-1:0]          fl_head;
    logic [PW-1:0]          fl_tail;
    logic [PW:0]            fl_count;

    logic                   accept;
    logic                   is_imm;
    backend_pkg::data_t     imm_ext;
    backend_pkg::preg_t     prs1;
    backend_pkg::preg_t     prs2;
    backend_pkg::preg_t     new_prd;

    logic                   dis_valid_q;
    backend_pkg::iq_entry_t ent_q;
    backend_pkg::areg_t     areg_q;
    backend_pkg::preg_t     old_prd_q;
    logic                   s1_q;
    logic                   s2_q;

    assign is_imm  = inst.r.opcode[3];
    assign imm_ext = {{10{inst.i.imm[5]}}, inst.i.imm};
    assign prs1    = rat_q[inst.r.rs1];
    assign prs2    = rat_q[inst.r.rs2];
    assign new_prd = fl_mem[fl_head];

    assign stall  = rob_full | iq_full | (fl_count == '0);
    assign accept = inst_valid & ~stall;

    // free list, busy table and alias table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                rat_q[i] <= backend_pkg::preg_t'(i);
            end
            for (int i = 0; i < NUM_PREG - NUM_AREG; i++) begin
                fl_mem[i] <= backend_pkg::preg_t'(NUM_AREG + i);
            end
            busy_q   <= '0;
            fl_head  <= '0;
            fl_tail  <= PW'(NUM_PREG - NUM_AREG);
            fl_count <= (PW + 1)'(NUM_PREG - NUM_AREG);
        end else begin
            if (wb.en) begin
                busy_q[wb.prd] <= 1'b0;
            end
            if (accept) begin
                busy_q[new_prd]     <= 1'b1;
                rat_q[inst.r.rd]    <= new_prd;
                fl_head <= (fl_head == PW'(NUM_PREG - 1)) ? '0 : fl_head + 1'b1;
            end
            if (free_en) begin
                fl_mem[fl_tail] <= free_preg;
                fl_tail <= (fl_tail == PW'(NUM_PREG - 1)) ? '0 : fl_tail + 1'b1;
            end
            fl_count <= fl_count + (PW + 1)'(free_en) - (PW + 1)'(accept);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dis_valid_q <= 1'b0;
        end else begin
            dis_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_q.op      <= inst.r.opcode;
            ent_q.prd     <= new_prd;
            ent_q.prs1    <= prs1;
            ent_q.prs2    <= prs2;
            ent_q.rs2_imm <= is_imm;
            ent_q.imm     <= imm_ext;
            ent_q.rob_idx <= '0;                // filled at dispatch
            areg_q        <= inst.r.rd;
            old_prd_q     <= rat_q[inst.r.rd];
            s1_q <= ~busy_q[prs1] | (wb.en && wb.prd == prs1);
            s2_q <= ~busy_q[prs2] | (wb.en && wb.prd == prs2);
        end
    end

    assign dis.valid   = dis_valid_q;
    assign dis.areg    = areg_q;
    assign dis.old_prd = old_prd_q;
    // catch a writeback landing in the dispatch cycle
    assign dis.src1_ready = s1_q | (wb.en && wb.prd == ent_q.prs1);
    assign dis.src2_ready = s2_q | (wb.en && wb.prd == ent_q.prs2);

    always_comb begin
        dis.entry         = ent_q;
        dis.entry.rob_idx = dis.rob_idx;
    end

endmodule

// File: logic/rob.sv
`timescale 1ns/1ns

module rob #(
    parameter int ROB_DEPTH = backend_pkg::ROB_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.rob_side        dis,
    wb_if.sink                  wb,
    output logic                rob_full,
    output logic                free_en,
    output backend_pkg::preg_t  free_preg,
    output logic                commit_en,
    output backend_pkg::areg_t  commit_areg,
    output backend_pkg::data_t  commit_data
);
    localparam int CW = $clog2(ROB_DEPTH + 1);

    backend_pkg::areg_t    areg_q    [ROB_DEPTH];
    backend_pkg::preg_t    old_prd_q [ROB_DEPTH];
    backend_pkg::data_t    data_q    [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  done_q;
    backend_pkg::rob_idx_t head;
    backend_pkg::rob_idx_t tail;
    logic [CW-1:0]         count;
    logic                  retire;

    assign retire      = (count != '0) && done_q[head];
    assign rob_full    = (count + dis.valid) >= ROB_DEPTH;  // room kept for pending dispatch
    assign dis.rob_idx = tail;

    always_ff @(posedge clk) begin
        if (dis.valid) begin
            areg_q[tail]    <= dis.areg;
            old_prd_q[tail] <= dis.old_prd;
        end
        if (wb.en) begin
            data_q[wb.rob_idx] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            done_q    <= '0;
            commit_en <= 1'b0;
            free_en   <= 1'b0;
        end else begin
            if (dis.valid) begin
                done_q[tail] <= 1'b0;
                tail <= (tail == backend_pkg::rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (wb.en) begin
                done_q[wb.rob_idx] <= 1'b1;
            end
            if (retire) begin
                head <= (head == backend_pkg::rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count     <= count + CW'(dis.valid) - CW'(retire);
            commit_en <= retire;
            free_en   <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_areg <= areg_q[head];
            commit_data <= data_q[head];
            free_preg   <= old_prd_q[head];  // previous mapping of rd
        end
    end

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
    parameter int IQ_DEPTH = backend_pkg::IQ_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    dispatch_if.iq_side             dis,
    wb_if.sink                      wb,
    output logic                    iq_full,
    output logic                    issue_en,
    output backend_pkg::iq_entry_t  issue_entry
);
    localparam int IW = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    backend_pkg::iq_entry_t entry_q [IQ_DEPTH];
    backend_pkg::rob_idx_t  age     [IQ_DEPTH];
    logic [IQ_DEPTH-1:0]    valid_q;
    logic [IQ_DEPTH-1:0]    rdy1_q;
    logic [IQ_DEPTH-1:0]    rdy2_q;
    logic [IQ_DEPTH-1:0]    rdy1_now;
    logic [IQ_DEPTH-1:0]    rdy2_now;
    logic [IW-1:0]          sel_idx;
    logic [IW-1:0]          free_idx;
    logic                   sel_found;
    backend_pkg::rob_idx_t  sel_age;

    assign iq_full = ($countones(valid_q) + dis.valid) >= IQ_DEPTH;

    // wakeup from this cycle's writeback
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            rdy1_now[i] = rdy1_q[i] | (wb.en && wb.prd == entry_q[i].prs1);
            rdy2_now[i] = rdy2_q[i] | (wb.en && wb.prd == entry_q[i].prs2);
            age[i]      = entry_q[i].rob_idx - dis.rob_idx;  // smaller is older
        end
    end

    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_age   = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (valid_q[i] && rdy1_now[i] && rdy2_now[i] &&
                (!sel_found || age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
                sel_age   = age[i];
            end
        end
    end

    // lowest empty slot
    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IW'(i);
            end
        end
    end

    assign issue_en    = sel_found;
    assign issue_entry = entry_q[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            rdy1_q  <= '0;
            rdy2_q  <= '0;
        end else begin
            rdy1_q <= rdy1_now;
            rdy2_q <= rdy2_now;
            if (sel_found) begin
                valid_q[sel_idx] <= 1'b0;
            end
            if (dis.valid) begin
                valid_q[free_idx] <= 1'b1;
                rdy1_q[free_idx]  <= dis.src1_ready;
                rdy2_q[free_idx]  <= dis.src2_ready | dis.entry.rs2_imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dis.valid) begin
            entry_q[free_idx] <= dis.entry;
        end
    end

endmodule

// File: logic/execute.sv
`timescale 1ns/1ns

module execute #(
    parameter int NUM_PREG = backend_pkg::NUM_PREG
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_en,
    input  backend_pkg::iq_entry_t  issue_entry,
    wb_if.source                    wb
);
    backend_pkg::data_t     prf [NUM_PREG];
    logic                   ex_valid;
    backend_pkg::iq_entry_t ex_q;
    backend_pkg::data_t     op_a;
    backend_pkg::data_t     op_b;
    backend_pkg::data_t     result;
    logic                   wb_en_q;
    backend_pkg::preg_t     wb_prd_q;
    backend_pkg::rob_idx_t  wb_rob_q;
    backend_pkg::data_t     wb_data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_en;
        end
        ex_q <= issue_entry;
    end

    assign op_a = prf[ex_q.prs1];
    assign op_b = ex_q.rs2_imm ? ex_q.imm : prf[ex_q.prs2];

    always_comb begin
        case (ex_q.op)
            backend_pkg::OP_ADD,
            backend_pkg::OP_ADDI: result = op_a + op_b;
            backend_pkg::OP_SUB:  result = op_a - op_b;
            backend_pkg::OP_AND,
            backend_pkg::OP_ANDI: result = op_a & op_b;
            backend_pkg::OP_XOR:  result = op_a ^ op_b;
            default:              result = '0;
        endcase
    end

    // regfile write and broadcast share one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREG; i++) begin
                prf[i] <= '0;
            end
            wb_en_q <= 1'b0;
        end else begin
            if (ex_valid) begin
                prf[ex_q.prd] <= result;
            end
            wb_en_q <= ex_valid;
        end
        wb_prd_q  <= ex_q.prd;
        wb_rob_q  <= ex_q.rob_idx;
        wb_data_q <= result;
    end

    assign wb.en      = wb_en_q;
    assign wb.prd     = wb_prd_q;
    assign wb.rob_idx = wb_rob_q;
    assign wb.data    = wb_data_q;

endmodule

// File: logic/backend.sv
`timescale 1ns/1ns

module backend #(
    parameter int NUM_AREG  = backend_pkg::NUM_AREG,
    parameter int NUM_PREG  = backend_pkg::NUM_PREG,
    parameter int ROB_DEPTH = backend_pkg::ROB_DEPTH,
    parameter int IQ_DEPTH  = backend_pkg::IQ_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  backend_pkg::inst_t  inst,
    output logic                stall,
    output logic                commit_en,
    output backend_pkg::areg_t  commit_areg,
    output backend_pkg::data_t  commit_data
);
    dispatch_if dis();
    wb_if       wb();

    logic                   free_en;
    backend_pkg::preg_t     free_preg;
    logic                   rob_full;
    logic                   iq_full;
    logic                   issue_en;
    backend_pkg::iq_entry_t issue_entry;

    rename #(
        .NUM_AREG (NUM_AREG),
        .NUM_PREG (NUM_PREG)
    ) u_rename (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .dis        (dis.rename_side),
        .wb         (wb.sink),
        .free_en    (free_en),
        .free_preg  (free_preg),
        .rob_full   (rob_full),
        .iq_full    (iq_full)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk         (clk),
        .rst         (rst),
        .dis         (dis.rob_side),
        .wb          (wb.sink),
        .rob_full    (rob_full),
        .free_en     (free_en),
        .free_preg   (free_preg),
        .commit_en   (commit_en),
        .commit_areg (commit_areg),
        .commit_data (commit_data)
    );

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_issue_queue (
        .clk         (clk),
        .rst         (rst),
        .dis         (dis.iq_side),
        .wb          (wb.sink),
        .iq_full     (iq_full),
        .issue_en    (issue_en),
        .issue_entry (issue_entry)
    );

    execute #(
        .NUM_PREG (NUM_PREG)
    ) u_execute (
        .clk         (clk),
        .rst         (rst),
        .issue_en    (issue_en),
        .issue_entry (issue_entry),
        .wb          (wb.source)
    );

endmodule

// File: dv/tb_backend.sv
`timescale 1ns/1ns

module tb_backend;
    localparam int MAX_INST = 32;
    localparam int TIMEOUT  = 300;
    localparam int DRAIN    = 20;

    logic               clk;
    logic               rst;
    logic               inst_valid;
    backend_pkg::inst_t inst;
    logic               stall;
    logic               commit_en;
    backend_pkg::areg_t commit_areg;
    backend_pkg::data_t commit_data;

    logic [15:0]        stim_mem  [3*MAX_INST];
    backend_pkg::inst_t inst_list [MAX_INST];
    backend_pkg::areg_t exp_areg  [MAX_INST];
    backend_pkg::data_t exp_data  [MAX_INST];
    int                 num_inst;
    int                 commit_idx;
    string              pass_name;
    logic               saw_stall;
    logic [31:0]        lfsr_state;

    backend u_dut (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .stall       (stall),
        .commit_en   (commit_en),
        .commit_areg (commit_areg),
        .commit_data (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_areg(input string name, input backend_pkg::areg_t expected,
                              input backend_pkg::areg_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: expected %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_data(input string name, input backend_pkg::data_t expected,
                              input backend_pkg::data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic load_stim();
        $readmemh("dv/backend_stim.txt", stim_mem);
        num_inst = 0;
        while (num_inst < MAX_INST && stim_mem[3*num_inst+1] != 16'hffff) begin
            inst_list[num_inst] = stim_mem[3*num_inst];
            exp_areg[num_inst]  = stim_mem[3*num_inst+1][2:0];
            exp_data[num_inst]  = stim_mem[3*num_inst+2];
            num_inst++;
        end
        if (num_inst == 0 || num_inst == MAX_INST) begin
            report_failure("stimulus file is missing, empty or has no end marker");
        end
    endtask

    task automatic apply_reset();
        rst        = 1'b1;
        inst_valid = 1'b0;
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
    endtask

    // hold the word until an edge with stall low takes it
    task automatic send_inst(input backend_pkg::inst_t word);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        inst       = word;
        inst_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = ~stall;
            if (stall) begin
                saw_stall = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited > TIMEOUT) begin
                report_failure("instruction was never accepted, stall stayed high");
            end
        end
        inst_valid = 1'b0;
    endtask

    task automatic run_pass(input string name, input logic use_gaps);
        int waited;
        int gap;
        pass_name = name;
        apply_reset();
        check_flag({name, " stall after reset"}, 1'b0, stall);
        check_flag({name, " commit_en after reset"}, 1'b0, commit_en);
        for (int n = 0; n < num_inst; n++) begin
            send_inst(inst_list[n]);
            if (use_gaps) begin
                draw_bits(2, gap);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        waited = 0;
        while (commit_idx < num_inst) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                report_failure($sformatf("%s pass timed out after %0d of %0d commits",
                                         name, commit_idx, num_inst));
            end
        end
        repeat (DRAIN) begin  // duplicates would show up here
            @(posedge clk);
        end
        #1;
    endtask

    // registered commit outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            commit_idx = 0;
        end else if (commit_en) begin
            if (commit_idx >= num_inst) begin
                report_failure($sformatf("%s pass committed more instructions than were sent",
                                         pass_name));
            end else begin
                check_areg($sformatf("%s inst %0d rd", pass_name, commit_idx),
                           exp_areg[commit_idx], commit_areg);
                check_data($sformatf("%s inst %0d value", pass_name, commit_idx),
                           exp_data[commit_idx], commit_data);
                commit_idx = commit_idx + 1;
            end
        end
    end

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        saw_stall  = 1'b0;
        lfsr_state = 32'h38ca1e08;
        pass_name  = "";
        load_stim();
        run_pass("burst", 1'b0);  // back to back
        if (!saw_stall) begin
            report_failure("stall never rose while instructions were sent back to back");
        end else begin
            run_pass("gapped", 1'b1);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: dv/backend_stim.txt
// columns: instruction word, expected destination register, expected committed value
// all hex, registers start at 0, the ffff line ends the list
8205 0001 0005
843d 0002 fffd
0650 0003 0002
1850 0004 0008
2a88 0005 0005
3ca0 0006 fff5
9f9f 0007 0015
90b8 0000 fff8
8260 0001 ffe5
8241 0001 ffe6
0248 0001 ffcc
825f 0001 ffeb
36c8 0003 ffe9
16e0 0003 ffe1
8a10 0005 0008
0258 0001 ffcc
944f 0002 000c
1c00 0006 0000
3928 0004 0000
8fff 0007 0014
ffff ffff ffff

// File: tb.f
logic/backend_pkg.sv
logic/backend_if.sv
logic/rename.sv
logic/rob.sv
logic/issue_queue.sv
logic/execute.sv
logic/backend.sv
dv/tb_backend.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_backend -f tb.f -o sim_backend \
    && ./obj_dir/sim_backend > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }
